// File: hdl/mmu_pkg.sv
package mmu_pkg;

    // =========================================================================
    // sizes
    // =========================================================================

    localparam int tlb_entries     = 16;
    localparam int req_queue_depth = 4;
    localparam int resp_credits    = 2;

    // global flag of a committed entry lives in entry_hi.unused.
    localparam int hi_global_bit   = 0;

    typedef logic [$clog2(tlb_entries)-1:0]       tlb_index_t;
    typedef logic [$clog2(req_queue_depth)-1:0]   req_ptr_t;
    typedef logic [$clog2(req_queue_depth+1)-1:0] req_count_t;
    typedef logic [$clog2(resp_credits+1)-1:0]    resp_count_t;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  asid_t;

    // =========================================================================
    // entry layouts
    // =========================================================================

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  unused;
        asid_t       asid;
    } entry_hi_t;

    typedef struct packed {
        logic [5:0]  unused;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entry_lo_t;

    typedef struct packed {
        entry_hi_t hi;
        entry_lo_t lo_even;
        entry_lo_t lo_odd;
    } tlb_entry_t;

    // one write word, seen as either register layout.
    typedef union packed {
        entry_hi_t hi;
        entry_lo_t lo;
    } cfg_word_u;

    typedef enum logic [2:0] {
        sel_hi      = 3'd0,
        sel_lo_even = 3'd1,
        sel_lo_odd  = 3'd2,
        sel_index   = 3'd3,
        sel_asid    = 3'd4,
        sel_commit  = 3'd5
    } cfg_sel_t;

    typedef struct packed {
        logic      en;
        cfg_sel_t  sel;
        cfg_word_u data;
    } cfg_wr_t;

    // =========================================================================
    // translation
    // =========================================================================

    typedef enum logic [1:0] {
        exc_none     = 2'd0,
        exc_refill   = 2'd1,
        exc_invalid  = 2'd2,
        exc_modified = 2'd3
    } exc_t;

    typedef struct packed {
        word_t vaddr;
        logic  store;
    } xlate_req_t;

    typedef struct packed {
        word_t      paddr;
        logic [2:0] c;
        exc_t       exc;
        tlb_index_t index;
    } xlate_resp_t;

    typedef struct packed {
        logic       hit;
        tlb_index_t index;
        word_t      paddr;
        logic [2:0] c;
        logic       d;
        logic       v;
    } lookup_res_t;

endpackage

// File: hdl/tlb_entry_file.sv
`timescale 1ns/100ps

module tlb_entry_file import mmu_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  cfg_wr_t    cfg_i,
    output tlb_entry_t entries_o [tlb_entries],
    output asid_t      asid_o
);

    entry_hi_t  stage_hi;
    entry_lo_t  stage_lo_even;
    entry_lo_t  stage_lo_odd;
    tlb_index_t stage_index;
    tlb_entry_t commit_entry;
    tlb_entry_t entries_q [tlb_entries];
    asid_t      asid_q;
    word_t      cfg_raw;

    // index is taken from the plain low bits of the word.
    assign cfg_raw = cfg_i.data;

    // =========================================================================
    // staging registers
    // =========================================================================

    always_ff @(posedge clk_i) begin
        if (cfg_i.en) begin
            case (cfg_i.sel)
                sel_hi: begin
                    stage_hi <= cfg_i.data.hi;
                end
                sel_lo_even: begin
                    stage_lo_even <= cfg_i.data.lo;
                end
                sel_lo_odd: begin
                    stage_lo_odd <= cfg_i.data.lo;
                end
                sel_index: begin
                    stage_index <= cfg_raw[$bits(tlb_index_t)-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // entry is global only when both lo words carry g.
    always_comb begin
        commit_entry = '{hi: stage_hi, lo_even: stage_lo_even, lo_odd: stage_lo_odd};
        commit_entry.hi.unused = '0;
        commit_entry.hi.unused[hi_global_bit] = stage_lo_even.g & stage_lo_odd.g;
    end

    // =========================================================================
    // entry array and current asid
    // =========================================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < tlb_entries; i++) begin
                entries_q[i] <= '0;
            end
            asid_q <= '0;
        end else if (cfg_i.en) begin
            if (cfg_i.sel == sel_commit) begin
                entries_q[stage_index] <= commit_entry;
            end
            if (cfg_i.sel == sel_asid) begin
                asid_q <= cfg_i.data.hi.asid;
            end
        end
    end

    assign entries_o = entries_q;
    assign asid_o    = asid_q;

endmodule

// File: hdl/tlb_lookup.sv
`timescale 1ns/100ps

module tlb_lookup import mmu_pkg::*; (
    input  tlb_entry_t  entries_i [tlb_entries],
    input  asid_t       asid_i,
    input  word_t       vaddr_i,
    output lookup_res_t result_o
);

    logic [tlb_entries-1:0] match;
    tlb_index_t             hit_index;
    tlb_entry_t             hit_entry;
    entry_lo_t              hit_lo;

    // =========================================================================
    // per-entry compare
    // =========================================================================

    genvar i;
    generate
        for (i = 0; i < tlb_entries; i++) begin : gen_match
            assign match[i] = (entries_i[i].hi.vpn2 == vaddr_i[31:13]) &&
                              ((entries_i[i].hi.asid == asid_i) ||
                               entries_i[i].hi.unused[hi_global_bit]);
        end
    endgenerate

    // lowest matching index wins.
    always_comb begin
        hit_index = '0;
        for (int n = tlb_entries - 1; n >= 0; n--) begin
            if (match[n]) begin
                hit_index = tlb_index_t'(n);
            end
        end
    end

    // =========================================================================
    // page select and result
    // =========================================================================

    assign hit_entry = entries_i[hit_index];

    // bit 12 picks the odd page of the pair.
    assign hit_lo = vaddr_i[12] ? hit_entry.lo_odd : hit_entry.lo_even;

    always_comb begin
        result_o.hit   = |match;
        result_o.index = hit_index;
        result_o.paddr = {hit_lo.pfn, vaddr_i[11:0]};
        result_o.c     = hit_lo.c;
        result_o.d     = hit_lo.d;
        result_o.v     = hit_lo.v;
    end

endmodule

// File: hdl/tlb_translate_pipe.sv
`timescale 1ns/100ps

module tlb_translate_pipe import mmu_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        req_valid_i,
    input  xlate_req_t  req_i,
    output logic        req_credit_o,
    output word_t       lookup_vaddr_o,
    input  lookup_res_t lookup_i,
    output logic        resp_valid_o,
    output xlate_resp_t resp_o,
    input  logic        resp_credit_i
);

    xlate_req_t  q_mem [req_queue_depth];
    req_ptr_t    wr_ptr;
    req_ptr_t    rd_ptr;
    req_count_t  q_count;
    xlate_req_t  head;
    logic        push;
    logic        pop;
    resp_count_t resp_cnt;
    logic        resp_avail;
    logic        resp_valid_q;
    xlate_resp_t resp_d;
    xlate_resp_t resp_q;
    logic        req_credit_q;

    // =========================================================================
    // request queue
    // =========================================================================

    assign push = req_valid_i;
    assign head = q_mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push) begin
            q_mem[wr_ptr] <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + req_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + req_ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + req_count_t'(1);
                2'b01:   q_count <= q_count - req_count_t'(1);
                default: q_count <= q_count;
            endcase
        end
    end

    assign lookup_vaddr_o = head.vaddr;

    // =========================================================================
    // response credits
    // =========================================================================

    // a response sitting in the output register has already claimed a credit.
    assign resp_avail = resp_cnt > resp_count_t'(resp_valid_q);
    assign pop        = (q_count != '0) && resp_avail;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_cnt <= resp_count_t'(resp_credits);
        end else begin
            case ({resp_credit_i, resp_valid_q})
                2'b10:   resp_cnt <= resp_cnt + resp_count_t'(1);
                2'b01:   resp_cnt <= resp_cnt - resp_count_t'(1);
                default: resp_cnt <= resp_cnt;
            endcase
        end
    end

    // =========================================================================
    // classification and response stage
    // =========================================================================

    always_comb begin
        resp_d.paddr = lookup_i.paddr;
        resp_d.c     = lookup_i.c;
        resp_d.index = lookup_i.index;
        if (!lookup_i.hit) begin
            resp_d.exc = exc_refill;
        end else if (!lookup_i.v) begin
            resp_d.exc = exc_invalid;
        end else if (head.store && !lookup_i.d) begin
            resp_d.exc = exc_modified;
        end else begin
            resp_d.exc = exc_none;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            resp_q <= resp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_valid_q <= 1'b0;
            req_credit_q <= 1'b0;
        end else begin
            resp_valid_q <= pop;
            req_credit_q <= pop;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;
    assign req_credit_o = req_credit_q;

endmodule

// File: hdl/mmu_top.sv
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  cfg_wr_t     cfg_i,
    input  logic        req_valid_i,
    input  xlate_req_t  req_i,
    output logic        req_credit_o,
    output logic        resp_valid_o,
    output xlate_resp_t resp_o,
    input  logic        resp_credit_i
);

    tlb_entry_t  entries [tlb_entries];
    asid_t       asid;
    word_t       lookup_vaddr;
    lookup_res_t lookup_res;

    tlb_entry_file u_entry_file (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .cfg_i     (cfg_i),
        .entries_o (entries),
        .asid_o    (asid)
    );

    tlb_lookup u_lookup (
        .entries_i (entries),
        .asid_i    (asid),
        .vaddr_i   (lookup_vaddr),
        .result_o  (lookup_res)
    );

    tlb_translate_pipe u_pipe (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .req_credit_o   (req_credit_o),
        .lookup_vaddr_o (lookup_vaddr),
        .lookup_i       (lookup_res),
        .resp_valid_o   (resp_valid_o),
        .resp_o         (resp_o),
        .resp_credit_i  (resp_credit_i)
    );

endmodule

// File: verification/mmu_props.sv
`timescale 1ns/100ps

module mmu_props import mmu_pkg::*; (
    input logic        clk_i,
    input logic        reset_i,
    input logic        resp_valid_i,
    input logic        req_credit_i,
    input resp_count_t resp_cnt_i,
    input req_count_t  q_count_i
);

    // a response in flight always holds a credit.
    resp_needs_credit: assert property (
        @(posedge clk_i) disable iff (reset_i) resp_valid_i |-> resp_cnt_i != '0
    ) else $error("response valid while the response credit count is zero");

    queue_bound: assert property (
        @(posedge clk_i) disable iff (reset_i) q_count_i <= req_count_t'(req_queue_depth)
    ) else $error("request queue holds more entries than its depth");

    // first cycle out of reset.
    quiet_after_reset: assert property (
        @(posedge clk_i) $fell(reset_i) |-> !resp_valid_i && !req_credit_i
    ) else $error("response or request credit active right after reset");

endmodule

bind tlb_translate_pipe mmu_props u_props (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .resp_valid_i (resp_valid_o),
    .req_credit_i (req_credit_o),
    .resp_cnt_i   (resp_cnt),
    .q_count_i    (q_count)
);

// File: verification/tb_mmu.sv
`timescale 1ns/100ps

module tb_mmu import mmu_pkg::*;;

    localparam int    wait_limit = 200;
    localparam int    exp_depth  = 256;
    localparam word_t lfsr_seed  = 32'h321c2f75;

    logic        clk = 1'b0;
    logic        reset_i;
    cfg_wr_t     cfg_i;
    logic        req_valid_i;
    xlate_req_t  req_i;
    logic        req_credit_o;
    logic        resp_valid_o;
    xlate_resp_t resp_o;
    logic        resp_credit_i = 1'b0;

    // reference copy of the entry array.
    logic [18:0] m_vpn2 [tlb_entries];
    asid_t       m_asid [tlb_entries];
    logic        m_glob [tlb_entries];
    entry_lo_t   m_lo_even [tlb_entries];
    entry_lo_t   m_lo_odd [tlb_entries];
    asid_t       m_cur_asid;

    xlate_resp_t exp_mem [exp_depth];
    word_t       lfsr;
    int          reqs_sent = 0;
    int          resp_received = 0;
    int          credits_returned = 0;
    int          credits_given = 0;
    int          err_main = 0;
    int          err_mon = 0;
    int          chk_main = 0;
    int          chk_mon = 0;
    int          tests_run = 0;
    logic        hold_credits = 1'b0;
    logic        timed_out = 1'b0;

    mmu_top i_dut (
        .clk_i         (clk),
        .reset_i       (reset_i),
        .cfg_i         (cfg_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_credit_o  (req_credit_o),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .resp_credit_i (resp_credit_i)
    );

    always #10 clk = ~clk;

    // ========================================================================
    // random bits and reference model
    // ========================================================================

    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic entry_hi_t rand_hi(input asid_t a);
        entry_hi_t hi;
        hi      = entry_hi_t'(rand_bits(32));
        hi.asid = a;
        return hi;
    endfunction

    function automatic entry_lo_t rand_lo(input logic v, input logic d, input logic g);
        entry_lo_t lo;
        lo   = entry_lo_t'(rand_bits(32));
        lo.v = v;
        lo.d = d;
        lo.g = g;
        return lo;
    endfunction

    function automatic word_t page_addr(input tlb_index_t idx, input logic odd);
        word_t w;
        w = rand_bits(12);
        return {m_vpn2[idx], odd, w[11:0]};
    endfunction

    function automatic xlate_resp_t model_translate(input word_t vaddr, input logic store);
        xlate_resp_t r;
        entry_lo_t   lo;
        int          hit;
        tlb_index_t  hidx;
        hit = -1;
        r   = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (m_vpn2[i] == vaddr[31:13] && (m_glob[i] || m_asid[i] == m_cur_asid)) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            r.exc = exc_refill;
            return r;
        end
        hidx    = tlb_index_t'(hit);
        lo      = vaddr[12] ? m_lo_odd[hidx] : m_lo_even[hidx];
        r.paddr = {lo.pfn, vaddr[11:0]};
        r.c     = lo.c;
        r.index = hidx;
        if (!lo.v) begin
            r.exc = exc_invalid;
        end else if (store && !lo.d) begin
            r.exc = exc_modified;
        end else begin
            r.exc = exc_none;
        end
        return r;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < tlb_entries; i++) begin
            m_vpn2[i]    = '0;
            m_asid[i]    = '0;
            m_glob[i]    = 1'b0;
            m_lo_even[i] = '0;
            m_lo_odd[i]  = '0;
        end
        m_cur_asid = '0;
    endtask

    // ========================================================================
    // run control and reporting
    // ========================================================================

    task automatic end_run();
        $display("tests %0d, checks %0d, errors %0d", tests_run, chk_main + chk_mon,
                 err_main + err_mon);
        if (err_main + err_mon == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        timed_out = 1'b1;
        err_main++;
        $display("timeout at %0t: %s", $time, what);
        end_run();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_main + err_mon == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_main + err_mon - errs_before);
        end
    endtask

    // ========================================================================
    // drivers
    // ========================================================================

    task automatic cfg_write(input cfg_sel_t sel, input word_t data);
        cfg_i = {1'b1, sel, data};
        @(posedge clk);
        #1;
        cfg_i.en = 1'b0;
    endtask

    task automatic load_entry(input tlb_index_t idx, input entry_hi_t hi,
                              input entry_lo_t lo_e, input entry_lo_t lo_o);
        cfg_write(sel_hi, hi);
        cfg_write(sel_lo_even, lo_e);
        cfg_write(sel_lo_odd, lo_o);
        cfg_write(sel_index, word_t'(idx));
        cfg_write(sel_commit, '0);
        m_vpn2[idx]    = hi.vpn2;
        m_asid[idx]    = hi.asid;
        m_glob[idx]    = lo_e.g & lo_o.g;
        m_lo_even[idx] = lo_e;
        m_lo_odd[idx]  = lo_o;
    endtask

    task automatic set_asid(input asid_t a);
        cfg_write(sel_asid, {24'h0, a});
        m_cur_asid = a;
    endtask

    task automatic send_req(input word_t vaddr, input logic store);
        logic [7:0] slot;
        int         waited;
        waited = 0;
        while (req_queue_depth + credits_returned - reqs_sent <= 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                abort_run("no request credit came back from the unit");
            end
        end
        slot          = 8'(reqs_sent);
        req_valid_i   = 1'b1;
        req_i         = '{vaddr: vaddr, store: store};
        exp_mem[slot] = model_translate(vaddr, store);
        reqs_sent++;
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    // waits until every response is in and all credits are home.
    task automatic drain();
        int waited;
        waited = 0;
        while (resp_received != reqs_sent || credits_returned != reqs_sent ||
               credits_given != resp_received) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > wait_limit) begin
                abort_run("outstanding responses or credits never arrived");
            end
        end
    endtask

    // consumer hands back one credit per cycle.
    always @(posedge clk) begin
        #1;
        if (!hold_credits && resp_received > credits_given) begin
            resp_credit_i = 1'b1;
            credits_given++;
        end else begin
            resp_credit_i = 1'b0;
        end
    end

    // ========================================================================
    // response monitor
    // ========================================================================

    task automatic check_response(input xlate_resp_t got);
        xlate_resp_t exp;
        logic [7:0]  slot;
        chk_mon++;
        assert (resp_received < reqs_sent) else begin
            $display("response arrived at %0t with no request outstanding", $time);
            err_mon++;
        end
        if (resp_received >= reqs_sent) begin
            return;
        end
        slot = 8'(resp_received);
        exp  = exp_mem[slot];
        chk_mon++;
        assert (got.exc == exp.exc) else begin
            $display("MISMATCH time %0t resp_o.exc got %0d expected %0d",
                     $time, got.exc, exp.exc);
            err_mon++;
        end
        // paddr, c and index carry no meaning on a refill.
        if (exp.exc != exc_refill) begin
            assert (got.paddr == exp.paddr) else begin
                $display("MISMATCH time %0t resp_o.paddr got %h expected %h",
                         $time, got.paddr, exp.paddr);
                err_mon++;
            end
            assert (got.c == exp.c) else begin
                $display("MISMATCH time %0t resp_o.c got %0d expected %0d",
                         $time, got.c, exp.c);
                err_mon++;
            end
            assert (got.index == exp.index) else begin
                $display("MISMATCH time %0t resp_o.index got %0d expected %0d",
                         $time, got.index, exp.index);
                err_mon++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset_i) begin
            if (req_credit_o) begin
                credits_returned++;
            end
            if (resp_valid_o) begin
                check_response(resp_o);
                resp_received++;
            end
        end
    end

    // ========================================================================
    // tests
    // ========================================================================

    task automatic test_reset_state();
        int    errs;
        word_t w;
        errs = err_main + err_mon;
        for (int k = 0; k < 4; k++) begin
            w = rand_bits(14);
            send_req({19'h0, w[12:0]}, w[13]);
        end
        drain();
        report_test("reset state", errs);
    endtask

    task automatic test_basic_hit();
        int    errs;
        word_t w;
        errs = err_main + err_mon;
        w = rand_bits(8);
        set_asid(w[7:0]);
        for (int i = 0; i < 8; i++) begin
            load_entry(tlb_index_t'(i), rand_hi(m_cur_asid),
                       rand_lo(1'b1, 1'b1, 1'b0), rand_lo(1'b1, 1'b1, 1'b0));
        end
        for (int k = 0; k < 20; k++) begin
            w = rand_bits(5);
            send_req(page_addr({1'b0, w[2:0]}, w[3]), w[4]);
        end
        drain();
        report_test("basic hit", errs);
    endtask

    task automatic test_refill();
        int    errs;
        word_t w;
        errs = err_main + err_mon;
        set_asid(m_cur_asid + 8'd1);
        for (int k = 0; k < 8; k++) begin
            w = rand_bits(4);
            send_req(page_addr({1'b0, w[2:0]}, w[3]), 1'b0);
        end
        for (int k = 0; k < 6; k++) begin
            send_req(rand_bits(32), 1'b0);
        end
        drain();
        set_asid(m_cur_asid - 8'd1);
        for (int k = 0; k < 6; k++) begin
            w = rand_bits(4);
            send_req(page_addr({1'b0, w[2:0]}, w[3]), 1'b0);
        end
        drain();
        report_test("refill", errs);
    endtask

    task automatic test_invalid_modified();
        int errs;
        errs = err_main + err_mon;
        // even page invalid, odd page valid but clean.
        load_entry(4'd12, rand_hi(m_cur_asid),
                   rand_lo(1'b0, 1'b1, 1'b0), rand_lo(1'b1, 1'b0, 1'b0));
        send_req(page_addr(4'd12, 1'b0), 1'b0);
        send_req(page_addr(4'd12, 1'b0), 1'b1);
        send_req(page_addr(4'd12, 1'b1), 1'b1);
        send_req(page_addr(4'd12, 1'b1), 1'b0);
        drain();
        report_test("invalid and modified", errs);
    endtask

    task automatic test_priority_global();
        int        errs;
        entry_hi_t hi;
        asid_t     other;
        errs  = err_main + err_mon;
        other = m_cur_asid ^ 8'h80;
        hi    = rand_hi(m_cur_asid);
        load_entry(4'd13, hi, rand_lo(1'b1, 1'b1, 1'b0), rand_lo(1'b1, 1'b1, 1'b0));
        load_entry(4'd14, hi, rand_lo(1'b1, 1'b1, 1'b0), rand_lo(1'b1, 1'b1, 1'b0));
        load_entry(4'd15, rand_hi(other), rand_lo(1'b1, 1'b1, 1'b1), rand_lo(1'b1, 1'b1, 1'b1));
        load_entry(4'd11, rand_hi(other), rand_lo(1'b1, 1'b1, 1'b1), rand_lo(1'b1, 1'b1, 1'b0));
        for (int k = 0; k < 3; k++) begin
            send_req(page_addr(4'd13, rand_bits(1) != 0), 1'b0);
            send_req(page_addr(4'd15, rand_bits(1) != 0), 1'b1);
            send_req(page_addr(4'd11, rand_bits(1) != 0), 1'b0);
        end
        drain();
        set_asid(other + 8'd3);
        send_req(page_addr(4'd15, 1'b0), 1'b0);
        send_req(page_addr(4'd15, 1'b1), 1'b0);
        drain();
        report_test("priority and global", errs);
    endtask

    task automatic test_backpressure();
        int    errs;
        int    base;
        word_t w;
        errs         = err_main + err_mon;
        base         = resp_received;
        hold_credits = 1'b1;
        for (int k = 0; k < req_queue_depth + resp_credits; k++) begin
            w = rand_bits(5);
            send_req(page_addr({1'b0, w[2:0]}, w[3]), w[4]);
        end
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        chk_main++;
        assert (resp_received - base == resp_credits) else begin
            $display("MISMATCH time %0t responses_while_held got %0d expected %0d",
                     $time, resp_received - base, resp_credits);
            err_main++;
        end
        chk_main++;
        assert (req_queue_depth + credits_returned - reqs_sent == 0) else begin
            $display("MISMATCH time %0t req_credits_held got %0d expected 0",
                     $time, req_queue_depth + credits_returned - reqs_sent);
            err_main++;
        end
        hold_credits = 1'b0;
        drain();
        report_test("credits under back-pressure", errs);
    endtask

    initial begin
        lfsr        = lfsr_seed;
        reset_i     = 1'b1;
        cfg_i       = '0;
        req_valid_i = 1'b0;
        req_i       = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;

        test_reset_state();
        test_basic_hit();
        test_refill();
        test_invalid_modified();
        test_priority_global();
        test_backpressure();
        end_run();
    end

endmodule

// File: project.f
hdl/mmu_pkg.sv
hdl/tlb_entry_file.sv
hdl/tlb_lookup.sv
hdl/tlb_translate_pipe.sv
hdl/mmu_top.sv
verification/mmu_props.sv
verification/tb_mmu.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mmu -f project.f

./obj_dir/Vtb_mmu > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
